// File: rtl/dcache_pkg.sv
/*
 * shared types of the write-through data cache
 * address, data and strobe types, core port structs,
 * APB request/response structs, FSM and opcode enums
 */
package dcache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  ////////////////////
  // core side ports
  ////////////////////

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } load_req_t;

  typedef struct packed {
    logic  rvalid;
    word_t rdata;
  } load_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t data;
    strb_t strb;
  } store_req_t;

  ////////////////////
  // memory side, APB
  ////////////////////

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
  } apb_rsp_t;

  // current miss unit job
  typedef enum logic [1:0] {OP_REFILL, OP_NC_READ, OP_WRITE} miss_op_e;

  typedef enum logic [1:0] {LD_IDLE, LD_LOOKUP, LD_MISS} load_state_e;
  typedef enum logic [1:0] {MU_IDLE, MU_SETUP, MU_ACCESS} miss_state_e;

endpackage

// File: rtl/dcache_mem.sv
/*
 * direct-mapped tag, valid and data arrays
 * two combinational lookup ports (load, store),
 * refill word write, byte-merged store write, clear-all
 */
`timescale 1ns/1ps

module dcache_mem #(
  parameter int unsigned NumLines  = 8,
  parameter int unsigned LineWords = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  dcache_pkg::addr_t ld_addr_i,
  input  dcache_pkg::addr_t st_addr_i,
  input  logic             refill_we_i,
  input  dcache_pkg::addr_t refill_addr_i,
  input  dcache_pkg::word_t refill_data_i,
  input  logic             refill_last_i,
  input  logic             st_we_i,
  input  dcache_pkg::word_t st_data_i,
  input  dcache_pkg::strb_t st_strb_i,
  input  logic             clear_all_i,
  output logic             ld_hit_o,
  output dcache_pkg::word_t ld_data_o,
  output logic             st_hit_o
);
  import dcache_pkg::*;

  localparam int unsigned OffW = $clog2(LineWords);
  localparam int unsigned IdxW = $clog2(NumLines);
  localparam int unsigned TagW = 32 - IdxW - OffW - 2;

  typedef struct packed {
    logic [TagW-1:0] tag;
    logic [IdxW-1:0] idx;
    logic [OffW-1:0] off;
    logic [1:0]      byte_off;
  } line_addr_t;

  word_t               data_q [NumLines][LineWords];
  logic [TagW-1:0]     tag_q  [NumLines];
  logic [NumLines-1:0] valid_q;

  line_addr_t ld, st, rf;

  assign ld = line_addr_t'(ld_addr_i);
  assign st = line_addr_t'(st_addr_i);
  assign rf = line_addr_t'(refill_addr_i);

  // tag compare on both ports
  assign ld_hit_o  = valid_q[ld.idx] && (tag_q[ld.idx] == ld.tag);
  assign ld_data_o = data_q[ld.idx][ld.off];
  assign st_hit_o  = valid_q[st.idx] && (tag_q[st.idx] == st.tag);

  // a line stays invalid until its last refill word lands
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_all_i) begin
      valid_q <= '0;
    end else if (refill_we_i) begin
      valid_q[rf.idx] <= refill_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_we_i) begin
      data_q[rf.idx][rf.off] <= refill_data_i;
      tag_q[rf.idx]          <= rf.tag;
    end else if (st_we_i) begin
      // merge store bytes into the cached word
      for (int b = 0; b < 4; b++) begin
        if (st_strb_i[b]) begin
          data_q[st.idx][st.off][8*b +: 8] <= st_data_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/dcache_load_ctrl.sv
/*
 * load port controller
 * grant, one-cycle array lookup, registered hit response,
 * refill or uncached read request to the miss unit
 */
`timescale 1ns/1ps

module dcache_load_ctrl #(
  parameter int unsigned NumLines  = 8,
  parameter int unsigned LineWords = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dcache_pkg::load_req_t  load_req_i,
  input  logic                   cache_en_i,
  input  logic                   hit_i,
  input  dcache_pkg::word_t      data_i,
  input  logic                   miss_ack_i,
  input  dcache_pkg::word_t      miss_rdata_i,
  output logic                   load_gnt_o,
  output dcache_pkg::load_rsp_t  load_rsp_o,
  output dcache_pkg::addr_t      lookup_addr_o,
  output logic                   miss_o,
  output logic                   miss_req_o,
  output logic                   miss_nc_o,
  output dcache_pkg::addr_t      miss_addr_o
);
  import dcache_pkg::*;

  localparam int unsigned OffW      = $clog2(LineWords);
  localparam int unsigned IdxW      = $clog2(NumLines);
  localparam int unsigned TagW      = 32 - IdxW - OffW - 2;
  localparam int unsigned WordAddrW = TagW + IdxW + OffW;

  load_state_e          state_q;
  logic [WordAddrW-1:0] waddr_q;
  logic                 nc_q;
  logic                 rvalid_q;
  word_t                rdata_q;

  // only accept a new load when nothing is in flight
  assign load_gnt_o    = (state_q == LD_IDLE) && load_req_i.valid;
  assign lookup_addr_o = {waddr_q, 2'b00};
  assign miss_addr_o   = {waddr_q, 2'b00};
  assign miss_o        = (state_q == LD_LOOKUP) && !hit_i;
  assign miss_req_o    = (state_q == LD_MISS);
  assign miss_nc_o     = nc_q;
  assign load_rsp_o    = '{rvalid: rvalid_q, rdata: rdata_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= LD_IDLE;
      nc_q     <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      case (state_q)
        LD_IDLE: begin
          if (load_gnt_o) begin
            // disabled cache goes straight to memory
            nc_q    <= !cache_en_i;
            state_q <= cache_en_i ? LD_LOOKUP : LD_MISS;
          end
        end
        LD_LOOKUP: begin
          rvalid_q <= hit_i;
          state_q  <= hit_i ? LD_IDLE : LD_MISS;
        end
        LD_MISS: begin
          if (miss_ack_i) begin
            rvalid_q <= 1'b1;
            state_q  <= LD_IDLE;
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_gnt_o) begin
      waddr_q <= load_req_i.addr[WordAddrW+1:2];
    end
    if (state_q == LD_LOOKUP) begin
      rdata_q <= data_i;
    end else if (miss_ack_i) begin
      rdata_q <= miss_rdata_i;
    end
  end

endmodule

// File: rtl/dcache_store_ctrl.sv
/*
 * store port controller
 * single-entry holding register, write-through request, hit update
 */
`timescale 1ns/1ps

module dcache_store_ctrl #(
  parameter int unsigned NumLines  = 8,
  parameter int unsigned LineWords = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dcache_pkg::store_req_t store_req_i,
  input  logic                   wr_ack_i,
  input  logic                   hit_i,
  output logic                   store_gnt_o,
  output logic                   store_idle_o,
  output logic                   wr_req_o,
  output dcache_pkg::addr_t      wr_addr_o,
  output dcache_pkg::word_t      wr_data_o,
  output dcache_pkg::strb_t      wr_strb_o,
  output logic                   mem_we_o
);
  import dcache_pkg::*;

  localparam int unsigned OffW      = $clog2(LineWords);
  localparam int unsigned IdxW      = $clog2(NumLines);
  localparam int unsigned WordAddrW = (32 - IdxW - OffW - 2) + IdxW + OffW;

  logic                 valid_q;
  logic [WordAddrW-1:0] waddr_q;
  word_t                data_q;
  strb_t                strb_q;

  // entry free means immediate grant
  assign store_gnt_o  = store_req_i.valid && !valid_q;
  assign store_idle_o = !valid_q && !store_gnt_o;
  assign wr_req_o     = valid_q;
  assign wr_addr_o    = {waddr_q, 2'b00};
  assign wr_data_o    = data_q;
  assign wr_strb_o    = strb_q;
  // cached copy only touched when the line is present
  assign mem_we_o     = wr_ack_i && hit_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (store_gnt_o) begin
      valid_q <= 1'b1;
    end else if (wr_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_gnt_o) begin
      waddr_q <= store_req_i.addr[WordAddrW+1:2];
      data_q  <= store_req_i.data;
      strb_q  <= store_req_i.strb;
    end
  end

endmodule

// File: rtl/dcache_miss_unit.sv
/*
 * miss unit and APB requester
 * serializes line refills, uncached reads and write-through stores,
 * handles flush and cache enable while idle
 */
`timescale 1ns/1ps

module dcache_miss_unit #(
  parameter int unsigned NumLines  = 8,
  parameter int unsigned LineWords = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 enable_i,
  input  logic                 flush_i,
  input  logic                 ld_miss_req_i,
  input  logic                 ld_miss_nc_i,
  input  dcache_pkg::addr_t    ld_miss_addr_i,
  input  logic                 st_wr_req_i,
  input  dcache_pkg::addr_t    st_wr_addr_i,
  input  dcache_pkg::word_t    st_wr_data_i,
  input  dcache_pkg::strb_t    st_wr_strb_i,
  input  dcache_pkg::apb_rsp_t apb_rsp_i,
  output logic                 flush_ack_o,
  output logic                 cache_en_o,
  output logic                 ld_miss_ack_o,
  output dcache_pkg::word_t    ld_miss_rdata_o,
  output logic                 st_wr_ack_o,
  output logic                 refill_we_o,
  output dcache_pkg::addr_t    refill_addr_o,
  output dcache_pkg::word_t    refill_data_o,
  output logic                 refill_last_o,
  output logic                 clear_all_o,
  output dcache_pkg::apb_req_t apb_req_o
);
  import dcache_pkg::*;

  localparam int unsigned OffW = $clog2(LineWords);
  localparam int unsigned IdxW = $clog2(NumLines);
  localparam int unsigned TagW = 32 - IdxW - OffW - 2;

  typedef struct packed {
    logic [TagW-1:0] tag;
    logic [IdxW-1:0] idx;
    logic [OffW-1:0] off;
    logic [1:0]      byte_off;
  } line_addr_t;

  miss_state_e state_q;
  miss_op_e    op_q;
  logic        flush_ack_q;
  logic        cache_en_q;
  line_addr_t  paddr_q;
  word_t       wdata_q;
  strb_t       strb_q;
  word_t       rdata_q;
  line_addr_t  ld_addr;
  logic        xfer_done;
  logic        word_hit;

  assign ld_addr   = line_addr_t'(ld_miss_addr_i);
  assign xfer_done = (state_q == MU_ACCESS) && apb_rsp_i.pready;
  // refill word that the load asked for
  assign word_hit  = (paddr_q.off == ld_addr.off);

  ////////////////////
  // array and port side
  ////////////////////

  assign refill_we_o     = xfer_done && (op_q == OP_REFILL);
  assign refill_addr_o   = paddr_q;
  assign refill_data_o   = apb_rsp_i.prdata;
  assign refill_last_o   = (paddr_q.off == {OffW{1'b1}});
  assign ld_miss_ack_o   = xfer_done &&
                           ((op_q == OP_NC_READ) || ((op_q == OP_REFILL) && refill_last_o));
  assign ld_miss_rdata_o = ((op_q == OP_NC_READ) || word_hit) ? apb_rsp_i.prdata : rdata_q;
  assign st_wr_ack_o     = xfer_done && (op_q == OP_WRITE);
  assign clear_all_o     = (state_q == MU_IDLE) && flush_i && !flush_ack_q;
  assign flush_ack_o     = flush_ack_q;
  assign cache_en_o      = cache_en_q;

  ////////////////////
  // APB side
  ////////////////////

  assign apb_req_o = '{psel:    (state_q != MU_IDLE),
                       penable: (state_q == MU_ACCESS),
                       pwrite:  (op_q == OP_WRITE),
                       paddr:   paddr_q,
                       pwdata:  wdata_q,
                       pstrb:   strb_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= MU_IDLE;
      op_q        <= OP_REFILL;
      flush_ack_q <= 1'b0;
      cache_en_q  <= 1'b0;
    end else begin
      flush_ack_q <= clear_all_o;
      case (state_q)
        MU_IDLE: begin
          cache_en_q <= enable_i;
          // flush holds off new jobs and loads beat stores
          if (!flush_i && ld_miss_req_i) begin
            op_q    <= ld_miss_nc_i ? OP_NC_READ : OP_REFILL;
            state_q <= MU_SETUP;
          end else if (!flush_i && st_wr_req_i) begin
            op_q    <= OP_WRITE;
            state_q <= MU_SETUP;
          end
        end
        MU_SETUP: state_q <= MU_ACCESS;
        MU_ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q <= (refill_we_o && !refill_last_o) ? MU_SETUP : MU_IDLE;
          end
        end
        default: state_q <= MU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == MU_IDLE) begin
      wdata_q <= st_wr_data_i;
      if (ld_miss_req_i) begin
        // refills start at word zero of the line
        paddr_q <= ld_miss_nc_i ? ld_addr :
                   line_addr_t'{tag: ld_addr.tag, idx: ld_addr.idx, off: '0, byte_off: 2'b00};
        strb_q  <= '0;
      end else begin
        paddr_q <= line_addr_t'(st_wr_addr_i);
        strb_q  <= st_wr_strb_i;
      end
    end else if (refill_we_o) begin
      paddr_q.off <= paddr_q.off + 1'b1;
      if (word_hit) begin
        rdata_q <= apb_rsp_i.prdata;
      end
    end
  end

endmodule

// File: rtl/dcache_top.sv
/*
 * data cache top level
 * load and store controllers, miss unit and arrays
 */
`timescale 1ns/1ps

module dcache_top #(
  parameter int unsigned NumLines  = 8,
  parameter int unsigned LineWords = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   enable_i,
  input  logic                   flush_i,
  output logic                   flush_ack_o,
  output logic                   miss_o,
  input  dcache_pkg::load_req_t  load_req_i,
  output logic                   load_gnt_o,
  output dcache_pkg::load_rsp_t  load_rsp_o,
  input  dcache_pkg::store_req_t store_req_i,
  output logic                   store_gnt_o,
  output logic                   store_idle_o,
  output dcache_pkg::apb_req_t   apb_req_o,
  input  dcache_pkg::apb_rsp_t   apb_rsp_i
);
  import dcache_pkg::*;

  logic  cache_en;
  addr_t lookup_addr;
  logic  ld_hit;
  word_t ld_data;
  // load controller and miss unit
  logic  ld_miss_req, ld_miss_nc, ld_miss_ack;
  addr_t ld_miss_addr;
  word_t ld_miss_rdata;
  // store controller and miss unit
  logic  st_wr_req, st_wr_ack, st_hit, st_mem_we;
  addr_t st_wr_addr;
  word_t st_wr_data;
  strb_t st_wr_strb;
  // miss unit and arrays
  logic  refill_we, refill_last, clear_all;
  addr_t refill_addr;
  word_t refill_data;

  dcache_load_ctrl #(
    .NumLines  ( NumLines  ),
    .LineWords ( LineWords )
  ) u_load_ctrl (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .load_req_i    ( load_req_i    ),
    .cache_en_i    ( cache_en      ),
    .hit_i         ( ld_hit        ),
    .data_i        ( ld_data       ),
    .miss_ack_i    ( ld_miss_ack   ),
    .miss_rdata_i  ( ld_miss_rdata ),
    .load_gnt_o    ( load_gnt_o    ),
    .load_rsp_o    ( load_rsp_o    ),
    .lookup_addr_o ( lookup_addr   ),
    .miss_o        ( miss_o        ),
    .miss_req_o    ( ld_miss_req   ),
    .miss_nc_o     ( ld_miss_nc    ),
    .miss_addr_o   ( ld_miss_addr  )
  );

  dcache_store_ctrl #(
    .NumLines  ( NumLines  ),
    .LineWords ( LineWords )
  ) u_store_ctrl (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .store_req_i  ( store_req_i  ),
    .wr_ack_i     ( st_wr_ack    ),
    .hit_i        ( st_hit       ),
    .store_gnt_o  ( store_gnt_o  ),
    .store_idle_o ( store_idle_o ),
    .wr_req_o     ( st_wr_req    ),
    .wr_addr_o    ( st_wr_addr   ),
    .wr_data_o    ( st_wr_data   ),
    .wr_strb_o    ( st_wr_strb   ),
    .mem_we_o     ( st_mem_we    )
  );

  dcache_miss_unit #(
    .NumLines  ( NumLines  ),
    .LineWords ( LineWords )
  ) u_miss_unit (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .enable_i        ( enable_i      ),
    .flush_i         ( flush_i       ),
    .ld_miss_req_i   ( ld_miss_req   ),
    .ld_miss_nc_i    ( ld_miss_nc    ),
    .ld_miss_addr_i  ( ld_miss_addr  ),
    .st_wr_req_i     ( st_wr_req     ),
    .st_wr_addr_i    ( st_wr_addr    ),
    .st_wr_data_i    ( st_wr_data    ),
    .st_wr_strb_i    ( st_wr_strb    ),
    .apb_rsp_i       ( apb_rsp_i     ),
    .flush_ack_o     ( flush_ack_o   ),
    .cache_en_o      ( cache_en      ),
    .ld_miss_ack_o   ( ld_miss_ack   ),
    .ld_miss_rdata_o ( ld_miss_rdata ),
    .st_wr_ack_o     ( st_wr_ack     ),
    .refill_we_o     ( refill_we     ),
    .refill_addr_o   ( refill_addr   ),
    .refill_data_o   ( refill_data   ),
    .refill_last_o   ( refill_last   ),
    .clear_all_o     ( clear_all     ),
    .apb_req_o       ( apb_req_o     )
  );

  dcache_mem #(
    .NumLines  ( NumLines  ),
    .LineWords ( LineWords )
  ) u_mem (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .ld_addr_i     ( lookup_addr ),
    .st_addr_i     ( st_wr_addr  ),
    .refill_we_i   ( refill_we   ),
    .refill_addr_i ( refill_addr ),
    .refill_data_i ( refill_data ),
    .refill_last_i ( refill_last ),
    .st_we_i       ( st_mem_we   ),
    .st_data_i     ( st_wr_data  ),
    .st_strb_i     ( st_wr_strb  ),
    .clear_all_i   ( clear_all   ),
    .ld_hit_o      ( ld_hit      ),
    .ld_data_o     ( ld_data     ),
    .st_hit_o      ( st_hit      )
  );

endmodule

// File: testbench/dcache_checker.sv
/*
 * protocol checker for the data cache, bound to dcache_top
 * APB setup and access rules, flush acknowledge pulse, load hit latency
 */
`timescale 1ns/1ps

module dcache_checker (
  input logic                  clk_i,
  input logic                  rst_i,
  input dcache_pkg::apb_req_t  apb_req_i,
  input dcache_pkg::apb_rsp_t  apb_rsp_i,
  input logic                  flush_ack_i,
  input logic                  load_gnt_i,
  input dcache_pkg::load_rsp_t load_rsp_i,
  input logic                  miss_i,
  input logic                  cache_en_i
);

  int unsigned fail_count = 0;

  apb_penable_needs_psel: assert property (@(posedge clk_i) disable iff (rst_i)
    apb_req_i.penable |-> apb_req_i.psel)
    else begin
      fail_count++;
      $error("APB penable high without psel");
    end

  // setup phase lasts exactly one cycle
  apb_setup_then_access: assert property (@(posedge clk_i) disable iff (rst_i)
    apb_req_i.psel && !apb_req_i.penable |=> apb_req_i.psel && apb_req_i.penable)
    else begin
      fail_count++;
      $error("APB setup not followed by access");
    end

  apb_fields_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    apb_req_i.psel && !(apb_req_i.penable && apb_rsp_i.pready) |=>
      $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) &&
      $stable(apb_req_i.pwdata) && $stable(apb_req_i.pstrb))
    else begin
      fail_count++;
      $error("APB fields changed before pready");
    end

  flush_ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_ack_i |=> !flush_ack_i)
    else begin
      fail_count++;
      $error("flush acknowledge longer than one cycle");
    end

  // a hit looks up one cycle after the grant and answers one cycle later
  load_hit_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(load_gnt_i && cache_en_i, 2) && $past(!miss_i) |-> load_rsp_i.rvalid)
    else begin
      fail_count++;
      $error("load hit response not two cycles after grant");
    end

endmodule

bind dcache_top dcache_checker u_checker (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .apb_req_i   ( apb_req_o   ),
  .apb_rsp_i   ( apb_rsp_i   ),
  .flush_ack_i ( flush_ack_o ),
  .load_gnt_i  ( load_gnt_o  ),
  .load_rsp_i  ( load_rsp_o  ),
  .miss_i      ( miss_o      ),
  .cache_en_i  ( cache_en    )
);

// File: testbench/tb_dcache.sv
/*
 * testbench for the write-through data cache
 * clock and reset, APB memory model with random wait states,
 * operation table, shadow memory and tag reference model, checks
 */
`timescale 1ns/1ps

module tb_dcache;
  import dcache_pkg::*;

  localparam int NumLines  = 8;
  localparam int LineWords = 4;
  localparam int ClkPeriod = 4;
  localparam int OffW      = $clog2(LineWords);
  localparam int IdxW      = $clog2(NumLines);
  localparam int MemWords  = 1024;
  // worst case per operation is a refill of five cycles per word plus handshakes
  localparam int OpCycles  = LineWords * 5 + 12;

  typedef enum logic [1:0] {K_LOAD, K_STORE, K_FLUSH, K_ENABLE} op_kind_e;

  typedef struct packed {
    op_kind_e kind;
    addr_t    addr;
    word_t    data;
    strb_t    strb;
    logic     exp_miss;
  } op_t;

  logic       clk, rst, enable, flush;
  logic       flush_ack, miss, load_gnt, store_gnt, store_idle;
  load_req_t  load_req;
  load_rsp_t  load_rsp;
  store_req_t store_req;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;

  word_t  mem_model [MemWords];
  word_t  shadow    [MemWords];
  logic   tag_valid [NumLines];
  addr_t  tag_table [NumLines];
  logic   model_en    = 1'b0;
  op_t    ops [$];
  logic   table_ready = 1'b0;
  integer seed        = 32'h08b0_8b43;
  int     rd_count    = 0;
  int     wr_count    = 0;
  strb_t  last_wr_strb;
  addr_t  last_wr_addr;

  dcache_top #(
    .NumLines  ( NumLines  ),
    .LineWords ( LineWords )
  ) u_dut (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .enable_i     ( enable     ),
    .flush_i      ( flush      ),
    .flush_ack_o  ( flush_ack  ),
    .miss_o       ( miss       ),
    .load_req_i   ( load_req   ),
    .load_gnt_o   ( load_gnt   ),
    .load_rsp_o   ( load_rsp   ),
    .store_req_i  ( store_req  ),
    .store_gnt_o  ( store_gnt  ),
    .store_idle_o ( store_idle ),
    .apb_req_o    ( apb_req    ),
    .apb_rsp_i    ( apb_rsp    )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic word_t init_word(addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] t=%0d ns %s: got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  ////////////////////
  // APB memory model
  ////////////////////

  task automatic serve_transfer();
    int idx;
    idx = apb_req.paddr[11:2];
    if (apb_req.paddr[31:12] != '0) begin
      stop_with_failure($sformatf("APB access to %h is outside the memory model",
                                  apb_req.paddr));
    end
    if (apb_req.pwrite) begin
      mem_model[idx] = merge_bytes(mem_model[idx], apb_req.pwdata, apb_req.pstrb);
      last_wr_strb   = apb_req.pstrb;
      last_wr_addr   = apb_req.paddr;
      wr_count++;
    end else begin
      apb_rsp.prdata = mem_model[idx];
      rd_count++;
    end
    apb_rsp.pready = 1'b1;
  endtask

  initial begin : apb_responder
    int waits;
    waits   = 0;
    apb_rsp = '0;
    forever begin
      @(posedge clk);
      #1;
      apb_rsp.pready = 1'b0;
      if (apb_req.psel && !apb_req.penable) begin
        waits = $random(seed) & 3;
      end else if (apb_req.psel && apb_req.penable) begin
        if (waits == 0) begin
          serve_transfer();
        end else begin
          waits--;
        end
      end
    end
  end

  ////////////////////
  // operations
  ////////////////////

  task automatic add_op(input op_kind_e kind, input addr_t addr, input word_t data,
                        input strb_t strb, input logic exp_miss);
    ops.push_back(op_t'{kind: kind, addr: addr, data: data, strb: strb,
                        exp_miss: exp_miss});
  endtask

  task automatic load_and_check(input op_t op);
    int    rd_before;
    int    wr_before;
    int    miss_seen;
    int    exp_reads;
    int    idx;
    addr_t tag;
    logic  model_miss;
    rd_before  = rd_count;
    wr_before  = wr_count;
    miss_seen  = 0;
    idx        = (op.addr >> (2 + OffW)) % NumLines;
    tag        = op.addr >> (2 + OffW + IdxW);
    model_miss = model_en && !(tag_valid[idx] && tag_table[idx] == tag);
    exp_reads  = !model_en ? 1 : (model_miss ? LineWords : 0);
    load_req.valid = 1'b1;
    load_req.addr  = op.addr;
    @(negedge clk);
    while (!load_gnt) @(negedge clk);
    @(posedge clk);
    #1;
    load_req.valid = 1'b0;
    do begin
      @(negedge clk);
      if (miss) miss_seen++;
    end while (!load_rsp.rvalid);
    check_value("table miss flag vs model", op.exp_miss, model_miss);
    check_value($sformatf("miss_o pulses, load %h", op.addr), miss_seen, op.exp_miss);
    check_value($sformatf("rdata, load %h", op.addr), load_rsp.rdata, shadow[op.addr[11:2]]);
    check_value("APB reads for load", rd_count - rd_before, exp_reads);
    check_value("APB writes for load", wr_count - wr_before, 0);
    if (model_miss) begin
      tag_valid[idx] = 1'b1;
      tag_table[idx] = tag;
    end
  endtask

  task automatic store_and_check(input op_t op);
    int rd_before;
    int wr_before;
    rd_before = rd_count;
    wr_before = wr_count;
    store_req = '{valid: 1'b1, addr: op.addr, data: op.data, strb: op.strb};
    @(negedge clk);
    while (!store_gnt) @(negedge clk);
    @(posedge clk);
    #1;
    store_req.valid = 1'b0;
    do @(negedge clk); while (!store_idle);
    check_value("APB writes for store", wr_count - wr_before, 1);
    check_value("APB reads for store", rd_count - rd_before, 0);
    check_value("pstrb", last_wr_strb, op.strb);
    check_value("paddr", last_wr_addr, {op.addr[31:2], 2'b00});
    shadow[op.addr[11:2]] = merge_bytes(shadow[op.addr[11:2]], op.data, op.strb);
  endtask

  task automatic flush_cache();
    flush = 1'b1;
    @(negedge clk);
    while (!flush_ack) @(negedge clk);
    @(posedge clk);
    #1;
    flush = 1'b0;
    for (int i = 0; i < NumLines; i++) begin
      tag_valid[i] = 1'b0;
    end
  endtask

  task automatic set_enable(input logic value);
    enable = value;
    // cache_en follows on the next edge while the miss unit is idle
    repeat (2) @(posedge clk);
    #1;
    model_en = value;
  endtask

  task automatic build_table();
    add_op(K_ENABLE, '0,         32'h1,         4'h0, 1'b0);
    add_op(K_LOAD,   32'h100,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h104,    '0,            4'h0, 1'b0);
    add_op(K_LOAD,   32'h10C,    '0,            4'h0, 1'b0);
    // partial store to a line that is not cached
    add_op(K_STORE,  32'h214,    32'hDEAD_BEEF, 4'h3, 1'b0);
    add_op(K_LOAD,   32'h214,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h218,    '0,            4'h0, 1'b0);
    // store hits update the cached copy
    add_op(K_STORE,  32'h108,    32'h1234_5678, 4'hF, 1'b0);
    add_op(K_LOAD,   32'h108,    '0,            4'h0, 1'b0);
    add_op(K_STORE,  32'h10C,    32'hA500_0000, 4'h8, 1'b0);
    add_op(K_LOAD,   32'h10C,    '0,            4'h0, 1'b0);
    // same index, other tag
    add_op(K_LOAD,   32'h180,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h104,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h184,    '0,            4'h0, 1'b1);
    add_op(K_FLUSH,  '0,         '0,            4'h0, 1'b0);
    add_op(K_LOAD,   32'h184,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h218,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h21C,    '0,            4'h0, 1'b0);
    // loads go straight to memory while the cache is disabled
    add_op(K_ENABLE, '0,         32'h0,         4'h0, 1'b0);
    add_op(K_LOAD,   32'h340,    '0,            4'h0, 1'b0);
    add_op(K_LOAD,   32'h340,    '0,            4'h0, 1'b0);
    add_op(K_STORE,  32'h344,    32'h0BAD_F00D, 4'h6, 1'b0);
    add_op(K_LOAD,   32'h344,    '0,            4'h0, 1'b0);
    add_op(K_ENABLE, '0,         32'h1,         4'h0, 1'b0);
    add_op(K_LOAD,   32'h340,    '0,            4'h0, 1'b1);
    add_op(K_LOAD,   32'h344,    '0,            4'h0, 1'b0);
    add_op(K_LOAD,   32'h188,    '0,            4'h0, 1'b0);
  endtask

  always @(negedge clk) begin
    if (u_dut.u_checker.fail_count != 0) begin
      stop_with_failure("a protocol assertion in the bound checker failed");
    end
  end

  initial begin : watchdog
    wait (table_ready);
    #((ops.size() * OpCycles + 16) * ClkPeriod);
    stop_with_failure($sformatf("timeout: %0d operations did not complete in time",
                                ops.size()));
  end

  initial begin : main_seq
    rst       = 1'b1;
    enable    = 1'b0;
    flush     = 1'b0;
    load_req  = '0;
    store_req = '0;
    for (int i = 0; i < MemWords; i++) begin
      mem_model[i] = init_word(addr_t'(i * 4));
      shadow[i]    = init_word(addr_t'(i * 4));
    end
    for (int i = 0; i < NumLines; i++) begin
      tag_valid[i] = 1'b0;
      tag_table[i] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (ops[n]) begin
      case (ops[n].kind)
        K_LOAD:   load_and_check(ops[n]);
        K_STORE:  store_and_check(ops[n]);
        K_FLUSH:  flush_cache();
        default:  set_enable(ops[n].data[0]);
      endcase
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    if (u_dut.u_checker.fail_count != 0) begin
      stop_with_failure("protocol assertions failed during the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: filelist.f
rtl/dcache_pkg.sv
rtl/dcache_mem.sv
rtl/dcache_load_ctrl.sv
rtl/dcache_store_ctrl.sv
rtl/dcache_miss_unit.sv
rtl/dcache_top.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dcache -f filelist.f --Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
